// File: rtl/hbm_cfg.svh
`ifndef HBM_CFG_SVH
`define HBM_CFG_SVH

// memory geometry shared by the package and every rtl block

`define HBM_DATA_W      64      // bits per word and width of one bank row
`define HBM_ADDR_W      9       // word address whose top half lies outside every window

`define HBM_NUM_BANKS   4       // one bank per crossbar master port
`define HBM_BANK_WORDS  64      // window length of each bank in words

// queueing
`define HBM_FIFO_DEPTH  4       // entries in both request and response fifo

`endif

// File: rtl/hbm_pkg.sv
`default_nettype none

`include "hbm_cfg.svh"

package hbm_pkg;

    localparam int STRB_W = `HBM_DATA_W / 8;            // one strobe per byte lane
    localparam int BANK_W = $clog2(`HBM_NUM_BANKS);     // bank select bits
    localparam int OFFS_W = $clog2(`HBM_BANK_WORDS);    // word index inside a bank

    // decoded request as it sits in the request fifo
    typedef struct packed {
        logic                       write;  // 1 = write, 0 = read
        logic                       err;    // address fell outside all windows
        logic [BANK_W-1:0]          bank;   // target bank
        logic [OFFS_W-1:0]          offs;   // word inside that bank
        logic [`HBM_DATA_W-1:0]     wdata;  // write payload ignored by reads
        logic [STRB_W-1:0]          wstrb;  // byte enables
    } hbm_req_t;

    // read response as it sits in the response fifo
    typedef struct packed {
        logic [`HBM_DATA_W-1:0]     rdata;  // zero on decode error
        logic                       err;    // decode error flag
    } hbm_rsp_t;

endpackage

`default_nettype wire

// File: rtl/hbm_req_router.sv
`default_nettype none

`include "hbm_cfg.svh"

module hbm_req_router (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        init_complete,  // banks cleared so the port may open
    input  logic                        req_valid,
    input  logic                        req_write,
    input  logic [`HBM_ADDR_W-1:0]      req_addr,       // word address
    input  logic [`HBM_DATA_W-1:0]      req_wdata,
    input  logic [hbm_pkg::STRB_W-1:0]  req_wstrb,
    input  logic                        fifo_full,      // request fifo has no room
    output logic                        req_ready,
    output logic                        fifo_push,
    output hbm_pkg::hbm_req_t           fifo_item
);
    import hbm_pkg::*;

    localparam int MAP_WORDS = `HBM_NUM_BANKS * `HBM_BANK_WORDS;  // end of last window

    logic in_map;   // address hits one of the bank windows

    assign req_ready = init_complete & ~fifo_full;              // space and init done
    assign fifo_push = req_valid & req_ready;                   // enters fifo on accept edge

    // the only place that knows the window layout
    assign in_map = 32'(req_addr) < MAP_WORDS;

    always_comb begin
        fifo_item.write = req_write;
        fifo_item.err   = ~in_map;                                  // default response path
        fifo_item.bank  = BANK_W'(req_addr / `HBM_BANK_WORDS);      // window index
        fifo_item.offs  = OFFS_W'(req_addr % `HBM_BANK_WORDS);      // word within window
        fifo_item.wdata = req_wdata;
        fifo_item.wstrb = req_wstrb;
    end

endmodule

`default_nettype wire

// File: rtl/hbm_fifo.sv
`default_nettype none

module hbm_fifo #(
    parameter type payload_t = logic,   // item carried by this queue
    parameter int  DEPTH     = 4        // any depth of 2 or more
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_item,
    input  logic     pop,
    output logic     full,
    output logic     empty,
    output payload_t head               // oldest item, valid while not empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);   // wrap point

    payload_t           mem [DEPTH];    // storage
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;          // occupancy
    logic               do_push;
    logic               do_pop;

    assign full    = count == CNT_W'(DEPTH);
    assign empty   = count == '0;
    assign do_push = push & ~full;      // push into a full fifo is dropped
    assign do_pop  = pop & ~empty;      // pop of an empty fifo does nothing
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;  // depth need not be 2^n
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // level unchanged on both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hbm_bank_array.sv
`default_nettype none

`include "hbm_cfg.svh"

module hbm_bank_array (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_empty,      // request fifo has nothing queued
    input  hbm_pkg::hbm_req_t   req_head,       // oldest request
    input  logic                rsp_full,       // response fifo has no room
    output logic                init_complete,
    output logic                req_pop,
    output logic                rsp_push,
    output hbm_pkg::hbm_rsp_t   rsp_item
);
    import hbm_pkg::*;

    localparam int NB = `HBM_NUM_BANKS;
    localparam logic [OFFS_W:0] INIT_END = (OFFS_W + 1)'(`HBM_BANK_WORDS);  // all rows done

    logic [OFFS_W:0]            init_cnt;       // next row to clear with an end marker bit
    logic                       clear_en;       // clearing one row in every bank
    logic [OFFS_W-1:0]          clr_offs;
    logic                       wr_en;          // mapped write leaves the queue
    logic [`HBM_DATA_W-1:0]     bank_rdata [NB];

    // init walk clears one row per clock in all banks together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_cnt      <= '0;
            init_complete <= 1'b0;
        end else if (!init_complete) begin
            if (init_cnt == INIT_END) begin
                init_complete <= 1'b1;          // one cycle after the last row is cleared
            end else begin
                init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    assign clear_en = ~init_complete & (init_cnt != INIT_END);
    assign clr_offs = init_cnt[OFFS_W-1:0];

    // writes leave as soon as they are queued and reads wait for response space
    assign req_pop  = init_complete & ~req_empty & (req_head.write | ~rsp_full);
    assign wr_en    = req_pop & req_head.write & ~req_head.err;     // unmapped write is dropped
    assign rsp_push = req_pop & ~req_head.write;                    // every read gets an answer

    for (genvar b = 0; b < NB; b++) begin : g_bank
        logic [`HBM_DATA_W-1:0] mem [`HBM_BANK_WORDS];  // one bank row per word
        logic                   sel;

        assign sel = wr_en && (req_head.bank == BANK_W'(b));

        always_ff @(posedge clk) begin
            if (clear_en) begin
                mem[clr_offs] <= '0;
            end else if (sel) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (req_head.wstrb[i]) begin
                        mem[req_head.offs][8*i +: 8] <= req_head.wdata[8*i +: 8];  // byte lane i
                    end
                end
            end
        end

        assign bank_rdata[b] = mem[req_head.offs];      // async read of the head's row
    end

    // response built in the same cycle as the pop
    always_comb begin
        rsp_item.err   = req_head.err;
        rsp_item.rdata = req_head.err ? '0 : bank_rdata[req_head.bank];  // error reads give zero
    end

endmodule

`default_nettype wire

// File: rtl/ram_wrapper.sv
`default_nettype none

`include "hbm_cfg.svh"

module ram_wrapper (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        init_complete,  // banks cleared after reset
    // request port
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_write,
    input  logic [`HBM_ADDR_W-1:0]      req_addr,
    input  logic [`HBM_DATA_W-1:0]      req_wdata,
    input  logic [hbm_pkg::STRB_W-1:0]  req_wstrb,
    // read response port
    output logic                        rd_valid,
    input  logic                        rd_ready,
    output logic [`HBM_DATA_W-1:0]      rd_data,
    output logic                        rd_err          // decode error on this read
);
    import hbm_pkg::*;

    logic       req_push;       // router into request fifo
    hbm_req_t   req_item;
    logic       req_full;
    logic       req_pop;        // bank array out of request fifo
    hbm_req_t   req_head;
    logic       req_empty;
    logic       rsp_push;       // bank array into response fifo
    hbm_rsp_t   rsp_item;
    logic       rsp_full;
    hbm_rsp_t   rsp_head;
    logic       rsp_empty;

    hbm_req_router u_req_router (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .init_complete ( init_complete ),
        .req_valid     ( req_valid     ),
        .req_write     ( req_write     ),
        .req_addr      ( req_addr      ),
        .req_wdata     ( req_wdata     ),
        .req_wstrb     ( req_wstrb     ),
        .fifo_full     ( req_full      ),
        .req_ready     ( req_ready     ),
        .fifo_push     ( req_push      ),
        .fifo_item     ( req_item      )
    );

    hbm_fifo #(
        .payload_t ( hbm_req_t        ),
        .DEPTH     ( `HBM_FIFO_DEPTH  )
    ) u_req_fifo (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .push      ( req_push  ),
        .push_item ( req_item  ),
        .pop       ( req_pop   ),
        .full      ( req_full  ),
        .empty     ( req_empty ),
        .head      ( req_head  )
    );

    hbm_bank_array u_bank_array (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .req_empty     ( req_empty     ),
        .req_head      ( req_head      ),
        .rsp_full      ( rsp_full      ),
        .init_complete ( init_complete ),
        .req_pop       ( req_pop       ),
        .rsp_push      ( rsp_push      ),
        .rsp_item      ( rsp_item      )
    );

    hbm_fifo #(
        .payload_t ( hbm_rsp_t        ),
        .DEPTH     ( `HBM_FIFO_DEPTH  )
    ) u_rsp_fifo (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .push      ( rsp_push  ),
        .push_item ( rsp_item  ),
        .pop       ( rd_ready  ),       // consumed on valid and ready
        .full      ( rsp_full  ),
        .empty     ( rsp_empty ),
        .head      ( rsp_head  )
    );

    assign rd_valid = ~rsp_empty;       // head is held until popped
    assign rd_data  = rsp_head.rdata;
    assign rd_err   = rsp_head.err;

endmodule

`default_nettype wire

// File: sim/ram_wrapper_props.sv
`default_nettype none

`include "hbm_cfg.svh"

module ram_wrapper_props (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     init_complete,
    input logic                     req_ready,
    input logic                     rd_valid,
    input logic                     rd_ready,
    input logic [`HBM_DATA_W-1:0]   rd_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // stalled response keeps its place and its data
    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data))
        else $error("read response changed while rd_ready was low");

    // port stays closed while the banks are being cleared
    a_ready_after_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_complete |-> !req_ready)
        else $error("req_ready high before init_complete");

    a_valid_after_init: assert property (@(posedge clk) disable iff (!rst_n)
        !init_complete |-> !rd_valid)     // no read can be accepted yet
        else $error("rd_valid high before init_complete");

endmodule

`default_nettype wire

// File: sim/ram_wrapper_tb.sv
`default_nettype none

`include "hbm_cfg.svh"

module ram_wrapper_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAP_WORDS  = `HBM_NUM_BANKS * `HBM_BANK_WORDS;  // 256 mapped words
    localparam int          WAIT_LIMIT = 200;       // cycles any single wait may spin
    localparam int          RAND_OPS   = 200;
    localparam logic [31:0] SEED       = 32'h7061;

    logic clk = 1'b0;
    logic rst_n, init_complete, req_valid, req_ready, req_write;
    logic rd_valid, rd_ready, rd_err;
    logic [`HBM_ADDR_W-1:0]     req_addr;
    logic [`HBM_DATA_W-1:0]     req_wdata, rd_data;
    logic [`HBM_DATA_W/8-1:0]   req_wstrb;

    logic [`HBM_DATA_W-1:0] model [MAP_WORDS];      // reference memory
    logic [`HBM_DATA_W:0]   exp_q [$];              // {err, data} per accepted read
    bit                     issue_done;             // issuer has sent its last request
    bit                     verdict_given;

    always #4 clk = ~clk;                           // 8 ns period

    ram_wrapper UUT (
        .clk(clk), .rst_n(rst_n), .init_complete(init_complete),
        .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_data(rd_data), .rd_err(rd_err)
    );

    bind ram_wrapper ram_wrapper_props u_props (
        .clk(clk), .rst_n(rst_n), .init_complete(init_complete), .req_ready(req_ready),
        .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_data(rd_data)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        verdict_given = 1'b1;
        $fatal(1, "stopped at first error");
    endtask

    // expected effect of one accepted request under the address map rules
    function automatic void model_apply(input bit wr, input int addr,
                                        input logic [63:0] data, input logic [7:0] strb);
        if (addr >= MAP_WORDS) begin
            if (!wr) exp_q.push_back({1'b1, 64'd0});    // unmapped read answers zero with err set
        end else if (wr) begin
            for (int i = 0; i < 8; i++) begin
                if (strb[i]) model[addr][8*i +: 8] = data[8*i +: 8];
            end
        end else begin
            exp_q.push_back({1'b0, model[addr]});
        end
    endfunction

    // called and returns on a falling edge
    task automatic issue(input bit wr, input int addr, input logic [63:0] data,
                         input logic [7:0] strb);
        int waited;
        waited     = 0;
        req_valid  = 1'b1;
        req_write  = wr;
        req_addr   = `HBM_ADDR_W'(addr);
        req_wdata  = data;
        req_wstrb  = strb;
        while (!req_ready) begin                    // fields held until accepted
            @(negedge clk);
            waited++;
            assert (waited < WAIT_LIMIT) else fail_now("request never accepted, req_ready low");
        end
        model_apply(wr, addr, data, strb);          // transfer on the coming rising edge
        @(negedge clk);
        req_valid  = 1'b0;
    endtask

    // consume responses in order until the issuer is done and nothing is outstanding
    task automatic collect(input bit random_ready);
        int                     idle;
        logic [`HBM_DATA_W:0]   want;
        idle = 0;
        while (!issue_done || exp_q.size() != 0) begin
            rd_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            if (rd_valid && rd_ready) begin
                assert (exp_q.size() != 0) else fail_now("read response with no read pending");
                want = exp_q.pop_front();
                assert (rd_err == want[64]) else fail_now($sformatf(
                    "Error: %0t rd_err expected %0b got %0b", $time, want[64], rd_err));
                assert (rd_data == want[63:0]) else fail_now($sformatf(
                    "Error: %0t rd_data expected %h got %h", $time, want[63:0], rd_data));
                idle = 0;
            end else if (exp_q.size() != 0) begin
                idle++;
                assert (idle < WAIT_LIMIT) else fail_now("timed out waiting for a read response");
            end
            @(negedge clk);
        end
        rd_ready = 1'b0;
    endtask

    task automatic flush;
        issue_done = 1'b1;
        collect(1'b0);
        issue_done = 1'b0;
    endtask

    task automatic reset_and_init;
        int cycles;
        cycles = 0;
        repeat (8) @(negedge clk);
        assert (!req_ready && !rd_valid && !init_complete)
            else fail_now("outputs not low while in reset");
        rst_n = 1'b1;
        @(negedge clk);                             // first rising edge after release is past
        while (!init_complete) begin
            assert (!req_ready) else fail_now($sformatf(
                "Error: %0t req_ready expected 0 got %0b", $time, req_ready));
            @(negedge clk);
            cycles++;
            assert (cycles < WAIT_LIMIT) else fail_now("init_complete never rose after reset");
        end
        assert (cycles == `HBM_BANK_WORDS) else fail_now($sformatf(
            "Error: %0t init_complete delay expected %0d got %0d", $time, `HBM_BANK_WORDS,
            cycles));
        for (int b = 0; b < `HBM_NUM_BANKS; b++) begin
            issue(1'b0, b * `HBM_BANK_WORDS, '0, '0);                     // first word
            issue(1'b0, b * `HBM_BANK_WORDS + `HBM_BANK_WORDS - 1, '0, '0);  // last word
        end
        flush();
    endtask

    // same offsets in every bank with different data
    task automatic bank_routing;
        for (int b = 0; b < `HBM_NUM_BANKS; b++) begin
            issue(1'b1, b * `HBM_BANK_WORDS + 5, {32'(b), 32'h5A5A_0005}, 8'hFF);
            issue(1'b1, b * `HBM_BANK_WORDS + 40, {32'(b), 32'hC3C3_0028}, 8'hFF);
        end
        for (int b = 0; b < `HBM_NUM_BANKS; b++) begin
            issue(1'b0, b * `HBM_BANK_WORDS + 5, '0, '0);
            issue(1'b0, b * `HBM_BANK_WORDS + 40, '0, '0);
        end
        flush();
    endtask

    task automatic byte_strobes;
        issue(1'b1, 77, 64'h0123_4567_89AB_CDEF, 8'hFF);
        issue(1'b1, 77, 64'hFFFF_FFFF_FFFF_FFFF, 8'h0F);    // low half only
        issue(1'b0, 77, '0, '0);
        issue(1'b1, 77, 64'h1122_3344_5566_7788, 8'hA5);    // scattered lanes
        issue(1'b0, 77, '0, '0);
        issue(1'b1, 77, 64'hDEAD_BEEF_0000_0000, 8'h80);
        issue(1'b1, 77, '1, 8'h00);                         // no lane enabled
        issue(1'b0, 77, '0, '0);
        flush();
    endtask

    task automatic decode_errors;
        for (int a = 5; a < MAP_WORDS; a += `HBM_BANK_WORDS) begin
            issue(1'b1, a, {32'(a), 32'h600D_F00D}, 8'hFF);
        end
        issue(1'b1, MAP_WORDS + 5, '1, 8'hFF);              // same low bits outside the map
        issue(1'b1, MAP_WORDS + 133, '1, 8'hFF);
        issue(1'b0, MAP_WORDS, '0, '0);
        issue(1'b0, 300, '0, '0);
        issue(1'b0, 511, '0, '0);
        for (int a = 5; a < MAP_WORDS; a += `HBM_BANK_WORDS) begin
            issue(1'b0, a, '0, '0);
        end
        flush();
    endtask

    task automatic back_pressure;
        int n;
        n = 0;
        rd_ready = 1'b0;
        while (req_ready) begin                     // both fifos fill and then the port closes
            issue(1'b0, (n * 37) % MAP_WORDS, '0, '0);
            n++;
            assert (n < 16) else fail_now("req_ready did not drop with rd_ready held low");
        end
        flush();
    endtask

    task automatic random_traffic;
        issue_done = 1'b0;
        fork
            begin
                for (int n = 0; n < RAND_OPS; n++) begin
                    issue(1'($urandom_range(0, 1)), int'($urandom_range(0, 299)),
                          {$urandom, $urandom}, 8'($urandom));
                end
                issue_done = 1'b1;
            end
            collect(1'b1);
        join
        issue_done = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_wdata     = '0;
        req_wstrb     = '0;
        rd_ready      = 1'b0;
        issue_done    = 1'b0;
        verdict_given = 1'b0;
        void'($urandom(SEED));
        for (int a = 0; a < MAP_WORDS; a++) model[a] = '0;  // banks come out of init cleared
        reset_and_init();
        bank_routing();
        byte_strobes();
        decode_errors();
        back_pressure();
        random_traffic();
        verdict_given = 1'b1;
        $display("TESTS PASSED");
        $finish;
    end

    final begin
        if (!verdict_given) begin
            $display("TESTS FAILED");
        end
    end

endmodule

`default_nettype wire

// File: ram_wrapper.f
+incdir+rtl
rtl/hbm_pkg.sv
rtl/hbm_req_router.sv
rtl/hbm_fifo.sv
rtl/hbm_bank_array.sv
rtl/ram_wrapper.sv
sim/ram_wrapper_props.sv
sim/ram_wrapper_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the ram_wrapper testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ram_wrapper_tb \
    -f ram_wrapper.f \
    -o sim_ram_wrapper

out=$(./obj_dir/sim_ram_wrapper 2>&1) || true
echo "$out"

if grep -q "TESTS PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi
